// File: cpu_golden.txt
# word count, then program words loaded at 1c000000
# then trace entries: pc  register  value
20
15000004
02bffc05
00121486
001290a7
001018a8
00111889
03aaf00a
03fffd4b
00142d4c
0040918d
0048fc8e
0017988f
1c000030
02801400
00102811
02840012
29802249
28802253
02800674
580008c7
5c0008c7
02844415
58000a2a
02844415
54000c00
50001000
02844415
02808816
4c000020
001006d7
00100018
50000000
1c000000 04 80000000
1c000004 05 ffffffff
1c000008 06 00000001
1c00000c 07 00000000
1c000010 08 00000000
1c000014 09 7fffffff
1c000018 0a 00000abc
1c00001c 0b 00000543
1c000020 0c fffff000
1c000024 0d ffff0000
1c000028 0e ffffffff
1c00002c 0f 40000000
1c000030 10 1c001030
1c000034 00 00000005
1c000038 11 00000abc
1c00003c 12 00000100
1c000044 13 7fffffff
1c000048 14 80000000
1c000060 01 1c000064
1c00006c 16 00000022
1c000070 00 1c000074
1c000074 17 1c000086
1c000078 18 00000000

// File: files.f
cpu_pkg.sv
alu.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
exe_stage.sv
mem_wb_stage.sv
cpu_top.sv
cpu_checker.sv
tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

SRCS := $(shell cat files.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): files.f $(SRCS)
	$(VERILATOR) --binary --timing --assert -f files.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG); grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam logic [31:0] reset_pc      = 32'h1c000000;
    localparam int          max_words     = 256;
    localparam int          trace_timeout = 2000;   // cycles
    localparam int          drain_cycles  = 20;

    logic        clk    = 1'b0;
    logic        resetn = 1'b0;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata = '0;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = '0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] prog     [0:max_words-1];
    logic [31:0] dmem     [0:max_words-1];
    logic [31:0] exp_pc   [0:max_words-1];
    logic [31:0] exp_wnum [0:max_words-1];
    logic [31:0] exp_data [0:max_words-1];
    int          n_prog;
    int          n_trace;
    int          trace_idx = 0;

    cpu_top #(.reset_pc(reset_pc)) dut (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #2 clk = ~clk;

    // word outside the loaded image reads as zero
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - reset_pc;
        if ((offs >> 2) < n_prog) begin
            return prog[offs[9:2]];
        end
        return 32'h0;
    endfunction

    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= fetch_word(inst_sram_addr);
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            if (data_sram_we == 4'hf) begin
                dmem[data_sram_addr[9:2]] <= data_sram_wdata;
            end
            data_sram_rdata <= dmem[data_sram_addr[9:2]];   // old word on a store
        end
    end

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("ERR time %0t %s expected %08h actual %08h",
                     $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // trace outputs are stable mid-cycle
    always @(negedge clk) begin
        if (resetn && debug_wb_rf_we != 4'h0) begin
            assert (trace_idx < n_trace) else begin
                $display("writeback at time %0t from pc %08h has no golden entry left",
                         $time, debug_wb_pc);
                $display("SIMULATION FAILED");
                $fatal(1);
            end
            check_word("debug_wb_pc", exp_pc[trace_idx], debug_wb_pc);
            check_word("debug_wb_rf_wnum", exp_wnum[trace_idx], {27'b0, debug_wb_rf_wnum});
            check_word("debug_wb_rf_wdata", exp_data[trace_idx], debug_wb_rf_wdata);
            trace_idx++;
        end
    end

    task automatic load_golden();
        int    fd;
        int    rc;
        string line;
        logic [31:0] a, b, c;
        fd = $fopen("cpu_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open cpu_golden.txt");
            $display("SIMULATION FAILED");
            $fatal(1);
        end
        rc = $fgets(line, fd);   // two comment lines
        rc = $fgets(line, fd);
        rc = $fscanf(fd, "%h\n", a);
        n_prog = int'(a);
        for (int i = 0; i < n_prog; i++) begin
            rc = $fscanf(fd, "%h\n", prog[i]);
        end
        n_trace = 0;
        while ($fscanf(fd, "%h %h %h\n", a, b, c) == 3) begin
            exp_pc[n_trace]   = a;
            exp_wnum[n_trace] = b;
            exp_data[n_trace] = c;
            n_trace++;
        end
        $fclose(fd);
    endtask

    initial begin
        int cycles;
        for (int i = 0; i < max_words; i++) begin
            dmem[i] = 32'h0;
            prog[i] = 32'h0;
        end
        load_golden();

        repeat (10) @(negedge clk);
        resetn = 1'b1;

        // trace_idx only moves on the falling edge
        cycles = 0;
        while (trace_idx < n_trace && cycles < trace_timeout) begin
            @(posedge clk);
            cycles++;
        end
        // extra cycles catch a stray wrong-path writeback
        repeat (drain_cycles) @(posedge clk);

        if (trace_idx == n_trace) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("timeout after %0d cycles with %0d of %0d writebacks seen",
                     cycles, trace_idx, n_trace);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

endmodule

// File: cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
    input logic           clk,
    input logic           resetn,
    input logic           inst_sram_en,
    input cpu_pkg::word_t inst_sram_addr,
    input logic           data_sram_en,
    input logic [3:0]     data_sram_we,
    input logic [3:0]     debug_wb_rf_we
);

    inst_aligned: assert property (@(posedge clk) disable iff (!resetn)
        inst_sram_en |-> inst_sram_addr[1:0] == 2'b00)
        else $error("instruction request not word aligned");

    we_needs_en: assert property (@(posedge clk) disable iff (!resetn)
        data_sram_we != 4'h0 |-> data_sram_en)
        else $error("data write enable without data request");

    trace_we_whole: assert property (@(posedge clk) disable iff (!resetn)
        debug_wb_rf_we == 4'h0 || debug_wb_rf_we == 4'hf)
        else $error("trace write enable bits disagree");

    // registers clear on the first reset edge so checking starts on the second
    quiet_in_reset: assert property (@(posedge clk)
        (!resetn && !$past(resetn)) |-> (!inst_sram_en && !data_sram_en
                                         && debug_wb_rf_we == 4'h0))
        else $error("request or writeback active during reset");

endmodule

bind cpu_top cpu_checker u_checker (.*);

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter cpu_pkg::word_t reset_pc = 32'h1c000000
) (
    input  logic                           clk,
    input  logic                           resetn,
    // instruction sram
    output logic                           inst_sram_en,
    output cpu_pkg::word_t                 inst_sram_addr,
    input  cpu_pkg::word_t                 inst_sram_rdata,
    // data sram
    output logic                           data_sram_en,
    output logic [cpu_pkg::word_bytes-1:0] data_sram_we,
    output cpu_pkg::word_t                 data_sram_addr,
    output cpu_pkg::word_t                 data_sram_wdata,
    input  cpu_pkg::word_t                 data_sram_rdata,
    // writeback trace
    output cpu_pkg::word_t                 debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_we,
    output cpu_pkg::reg_idx_t              debug_wb_rf_wnum,
    output cpu_pkg::word_t                 debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic     fs_to_ds_valid, ds_allowin, br_taken;
    word_t    fs_pc, fs_inst, br_target;

    reg_idx_t rf_raddr1, rf_raddr2, rf_waddr;
    word_t    rf_rdata1, rf_rdata2, rf_wdata;
    logic     rf_we;

    logic     ds_to_es_valid, ds_rf_we, ds_mem_we, ds_is_load;
    word_t    ds_pc, ds_src1, ds_src2, ds_st_data;
    alu_op_e  ds_alu_op;
    reg_idx_t ds_dest;

    logic     es_valid, es_rf_we, es_is_load;
    reg_idx_t es_dest;
    word_t    es_result, es_pc;

    logic     ms_valid, ms_rf_we, ws_valid, ws_rf_we;
    reg_idx_t ms_dest, ws_dest;
    word_t    ms_result, ws_result;

    fetch_stage #(.reset_pc(reset_pc)) u_fetch (.*);

    decode_stage u_decode (.*);

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    exe_stage u_exe (.*);

    mem_wb_stage u_mem_wb (.*);

endmodule

// File: mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic              clk, resetn,
    input  logic              es_valid, es_rf_we, es_is_load,
    input  cpu_pkg::reg_idx_t es_dest,
    input  cpu_pkg::word_t    es_result, es_pc,
    input  cpu_pkg::word_t    data_sram_rdata,
    output logic              ms_valid, ms_rf_we,
    output cpu_pkg::reg_idx_t ms_dest,
    output cpu_pkg::word_t    ms_result,
    output logic              ws_valid, ws_rf_we,
    output cpu_pkg::reg_idx_t ws_dest,
    output cpu_pkg::word_t    ws_result,
    output logic              rf_we,
    output cpu_pkg::reg_idx_t rf_waddr,
    output cpu_pkg::word_t    rf_wdata,
    output cpu_pkg::word_t    debug_wb_pc,
    output logic [3:0]        debug_wb_rf_we,
    output cpu_pkg::reg_idx_t debug_wb_rf_wnum,
    output cpu_pkg::word_t    debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic  ms_is_load;
    word_t ms_alu_result, ms_pc, ws_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_valid <= 1'b0;
            ws_valid <= 1'b0;
        end else begin
            ms_valid <= es_valid;
            ws_valid <= ms_valid;
        end
        if (es_valid) begin
            ms_rf_we      <= es_rf_we;
            ms_is_load    <= es_is_load;
            ms_dest       <= es_dest;
            ms_alu_result <= es_result;
            ms_pc         <= es_pc;
        end
        if (ms_valid) begin
            ws_rf_we  <= ms_rf_we;
            ws_dest   <= ms_dest;
            ws_result <= ms_result;
            ws_pc     <= ms_pc;
        end
    end

    // sram word shows up the cycle after the exe request
    assign ms_result = ms_is_load ? data_sram_rdata : ms_alu_result;

    assign rf_we    = ws_valid && ws_rf_we;
    assign rf_waddr = ws_dest;
    assign rf_wdata = ws_result;

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = ws_result;

endmodule

// File: exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                           clk, resetn,
    input  logic                           ds_to_es_valid,
    input  cpu_pkg::word_t                 ds_pc,
    input  cpu_pkg::alu_op_e               ds_alu_op,
    input  cpu_pkg::word_t                 ds_src1, ds_src2, ds_st_data,
    input  cpu_pkg::reg_idx_t              ds_dest,
    input  logic                           ds_rf_we, ds_mem_we, ds_is_load,
    output logic                           data_sram_en,
    output logic [cpu_pkg::word_bytes-1:0] data_sram_we,
    output cpu_pkg::word_t                 data_sram_addr, data_sram_wdata,
    output logic                           es_valid, es_rf_we, es_is_load,
    output cpu_pkg::reg_idx_t              es_dest,
    output cpu_pkg::word_t                 es_result, es_pc
);
    import cpu_pkg::*;

    alu_op_e es_alu_op;
    word_t   es_src1, es_src2, es_st_data;
    logic    es_mem_we;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else begin
            es_valid <= ds_to_es_valid;   // bubble when decode holds
        end
        if (ds_to_es_valid) begin
            es_pc      <= ds_pc;
            es_alu_op  <= ds_alu_op;
            es_src1    <= ds_src1;
            es_src2    <= ds_src2;
            es_st_data <= ds_st_data;
            es_dest    <= ds_dest;
            es_rf_we   <= ds_rf_we;
            es_mem_we  <= ds_mem_we;
            es_is_load <= ds_is_load;
        end
    end

    alu u_alu (
        .alu_op     (es_alu_op),
        .alu_src1   (es_src1),
        .alu_src2   (es_src2),
        .alu_result (es_result)
    );

    assign data_sram_en    = es_valid && (es_is_load || es_mem_we);
    assign data_sram_we    = {word_bytes{es_valid && es_mem_we}};   // word stores only
    assign data_sram_addr  = es_result;
    assign data_sram_wdata = es_st_data;

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk, resetn,
    input  logic              fs_to_ds_valid,
    input  cpu_pkg::word_t    fs_pc, fs_inst,
    output logic              ds_allowin, br_taken,
    output cpu_pkg::word_t    br_target,
    output cpu_pkg::reg_idx_t rf_raddr1, rf_raddr2,
    input  cpu_pkg::word_t    rf_rdata1, rf_rdata2,
    input  logic              es_valid, es_rf_we, es_is_load,
    input  cpu_pkg::reg_idx_t es_dest,
    input  cpu_pkg::word_t    es_result,
    input  logic              ms_valid, ms_rf_we,
    input  cpu_pkg::reg_idx_t ms_dest,
    input  cpu_pkg::word_t    ms_result,
    input  logic              ws_valid, ws_rf_we,
    input  cpu_pkg::reg_idx_t ws_dest,
    input  cpu_pkg::word_t    ws_result,
    output logic              ds_to_es_valid,
    output cpu_pkg::word_t    ds_pc,
    output cpu_pkg::alu_op_e  ds_alu_op,
    output cpu_pkg::word_t    ds_src1, ds_src2, ds_st_data,
    output cpu_pkg::reg_idx_t ds_dest,
    output logic              ds_rf_we, ds_mem_we, ds_is_load
);
    import cpu_pkg::*;

    logic        ds_valid, ds_ready_go;
    word_t       ds_inst;
    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    reg_idx_t    rd, rj, rk;
    logic        op17_hit, r3_hit, sh_hit, ri_hit, ui12;
    alu_op_e     op17_op, ri_op;
    logic        is_ld, is_st, is_lu12i, is_pcadd;
    logic        is_jirl, is_b, is_bl, is_beq, is_bne;
    logic        rj_need, rk_need, rd_need;
    logic        es_hit1, es_hit2, ms_hit1, ms_hit2, ws_hit1, ws_hit2;
    word_t       imm, br_offs, rj_value, rkd_value;

    // producer in flight that writes the register this source reads
    function automatic logic dep(input logic v, input logic we, input reg_idx_t dst,
                                 input reg_idx_t src, input logic need);
        return need && v && we && (dst != '0) && (dst == src);
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    assign op17 = ds_inst[31:15];
    assign op10 = ds_inst[31:22];
    assign op7  = ds_inst[31:25];
    assign op6  = ds_inst[31:26];
    assign rd   = ds_inst[4:0];
    assign rj   = ds_inst[9:5];
    assign rk   = ds_inst[14:10];

    always_comb begin
        op17_hit = 1'b1;
        op17_op  = alu_add;
        case (op17)
            op_add_w:            op17_op = alu_add;
            op_sub_w:            op17_op = alu_sub;
            op_slt:              op17_op = alu_slt;
            op_sltu:             op17_op = alu_sltu;
            op_nor:              op17_op = alu_nor;
            op_and:              op17_op = alu_and;
            op_or:               op17_op = alu_or;
            op_xor:              op17_op = alu_xor;
            op_sll_w, op_slli_w: op17_op = alu_sll;
            op_srl_w, op_srli_w: op17_op = alu_srl;
            op_sra_w, op_srai_w: op17_op = alu_sra;
            default:             op17_hit = 1'b0;
        endcase
    end

    always_comb begin
        ri_hit = 1'b1;
        ri_op  = alu_add;
        case (op10)
            op_addi_w: ri_op = alu_add;
            op_slti:   ri_op = alu_slt;
            op_sltui:  ri_op = alu_sltu;
            op_andi:   ri_op = alu_and;
            op_ori:    ri_op = alu_or;
            op_xori:   ri_op = alu_xor;
            default:   ri_hit = 1'b0;
        endcase
    end

    assign sh_hit   = op17 inside {op_slli_w, op_srli_w, op_srai_w};
    assign r3_hit   = op17_hit && !sh_hit;
    assign ui12     = op10 inside {op_andi, op_ori, op_xori};   // zero-extended
    assign is_ld    = op10 == op_ld_w;
    assign is_st    = op10 == op_st_w;
    assign is_lu12i = op7 == op_lu12i_w;
    assign is_pcadd = op7 == op_pcaddu12i;
    assign is_jirl  = op6 == op_jirl;
    assign is_b     = op6 == op_b;
    assign is_bl    = op6 == op_bl;
    assign is_beq   = op6 == op_beq;
    assign is_bne   = op6 == op_bne;

    // shift amounts ride in i12 and the alu only looks at [4:0]
    assign imm = (is_jirl || is_bl)     ? 32'd4 :     // link = pc + 4
                 (is_lu12i || is_pcadd) ? {ds_inst[24:5], 12'b0} :
                 ui12                   ? {20'b0, ds_inst[21:10]} :
                                          {{20{ds_inst[21]}}, ds_inst[21:10]};
    assign br_offs = (is_b || is_bl) ? {{4{ds_inst[9]}}, ds_inst[9:0], ds_inst[25:10], 2'b0}
                                     : {{14{ds_inst[25]}}, ds_inst[25:10], 2'b0};

    assign rj_need   = r3_hit || sh_hit || ri_hit || is_ld || is_st || is_jirl || is_beq || is_bne;
    assign rk_need   = r3_hit;
    assign rd_need   = is_st || is_beq || is_bne;
    assign rf_raddr1 = rj;
    assign rf_raddr2 = rd_need ? rd : rk;

    // youngest producer wins
    assign es_hit1 = dep(es_valid, es_rf_we, es_dest, rf_raddr1, rj_need);
    assign es_hit2 = dep(es_valid, es_rf_we, es_dest, rf_raddr2, rk_need || rd_need);
    assign ms_hit1 = dep(ms_valid, ms_rf_we, ms_dest, rf_raddr1, rj_need);
    assign ms_hit2 = dep(ms_valid, ms_rf_we, ms_dest, rf_raddr2, rk_need || rd_need);
    assign ws_hit1 = dep(ws_valid, ws_rf_we, ws_dest, rf_raddr1, rj_need);
    assign ws_hit2 = dep(ws_valid, ws_rf_we, ws_dest, rf_raddr2, rk_need || rd_need);

    assign rj_value  = es_hit1 ? es_result : ms_hit1 ? ms_result : ws_hit1 ? ws_result : rf_rdata1;
    assign rkd_value = es_hit2 ? es_result : ms_hit2 ? ms_result : ws_hit2 ? ws_result : rf_rdata2;

    // load data is only ready once the load sits in memory
    assign ds_ready_go    = !(es_is_load && (es_hit1 || es_hit2));
    assign ds_allowin     = !ds_valid || ds_ready_go;
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    assign br_taken  = ds_to_es_valid && ((is_beq && rj_value == rkd_value)
                     || (is_bne && rj_value != rkd_value) || is_jirl || is_b || is_bl);
    assign br_target = is_jirl ? rj_value + br_offs : ds_pc + br_offs;

    assign ds_alu_op  = op17_hit ? op17_op : ri_hit ? ri_op : is_lu12i ? alu_lui : alu_add;
    assign ds_src1    = (is_jirl || is_bl || is_pcadd) ? ds_pc : rj_value;
    assign ds_src2    = r3_hit ? rkd_value : imm;
    assign ds_st_data = rkd_value;
    assign ds_dest    = is_bl ? 5'd1 : rd;
    assign ds_rf_we   = op17_hit || ri_hit || is_ld || is_lu12i || is_pcadd || is_jirl || is_bl;
    assign ds_mem_we  = is_st;
    assign ds_is_load = is_ld;

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter cpu_pkg::word_t reset_pc = 32'h1c000000
) (
    input  logic           clk,
    input  logic           resetn,
    input  logic           ds_allowin,
    input  logic           br_taken,
    input  cpu_pkg::word_t br_target,
    input  cpu_pkg::word_t inst_sram_rdata,
    output logic           inst_sram_en,
    output cpu_pkg::word_t inst_sram_addr,
    output logic           fs_to_ds_valid,
    output cpu_pkg::word_t fs_pc,
    output cpu_pkg::word_t fs_inst
);
    import cpu_pkg::*;

    logic  fs_valid;
    logic  fs_run;     // low during reset, then high for good
    word_t seq_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_run   <= 1'b0;
            fs_valid <= 1'b0;
            fs_pc    <= reset_pc - word_t'(word_bytes);  // first request lands on reset_pc
        end else begin
            fs_run <= 1'b1;
            if (ds_allowin) begin
                fs_valid <= fs_run;   // a request went out this cycle
            end
            if (inst_sram_en) begin
                fs_pc <= inst_sram_addr;
            end
        end
    end

    assign seq_pc         = fs_pc + word_t'(word_bytes);
    assign inst_sram_en   = fs_run && ds_allowin;   // sram holds its output on a stall
    assign inst_sram_addr = br_taken ? br_target : seq_pc;

    // wrong-path slot behind a taken branch never reaches decode
    assign fs_to_ds_valid = fs_valid && !br_taken;
    assign fs_inst        = inst_sram_rdata;

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  cpu_pkg::reg_idx_t raddr1,
    input  cpu_pkg::reg_idx_t raddr2,
    input  logic              we,
    input  cpu_pkg::reg_idx_t waddr,
    input  cpu_pkg::word_t    wdata,
    output cpu_pkg::word_t    rdata1,
    output cpu_pkg::word_t    rdata2
);
    import cpu_pkg::*;

    word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;   // r0 may be written, never read back
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e alu_op,
    input  cpu_pkg::word_t   alu_src1,
    input  cpu_pkg::word_t   alu_src2,
    output cpu_pkg::word_t   alu_result
);
    import cpu_pkg::*;

    logic [4:0] sa;

    assign sa = alu_src2[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  alu_result = alu_src1 + alu_src2;
            alu_sub:  alu_result = alu_src1 - alu_src2;
            alu_slt:  alu_result = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
            alu_sltu: alu_result = {31'b0, alu_src1 < alu_src2};
            alu_and:  alu_result = alu_src1 & alu_src2;
            alu_nor:  alu_result = ~(alu_src1 | alu_src2);
            alu_or:   alu_result = alu_src1 | alu_src2;
            alu_xor:  alu_result = alu_src1 ^ alu_src2;
            alu_sll:  alu_result = alu_src1 << sa;
            alu_srl:  alu_result = alu_src1 >> sa;
            alu_sra:  alu_result = word_t'($signed(alu_src1) >>> sa);
            alu_lui:  alu_result = alu_src2;   // immediate already shifted up
            default:  alu_result = '0;
        endcase
    end

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int unsigned word_bytes = 4;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or,  alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    // inst[31:15] for 3R and shift-by-immediate
    localparam logic [16:0] op_add_w  = 17'h00020;
    localparam logic [16:0] op_sub_w  = 17'h00022;
    localparam logic [16:0] op_slt    = 17'h00024;
    localparam logic [16:0] op_sltu   = 17'h00025;
    localparam logic [16:0] op_nor    = 17'h00028;
    localparam logic [16:0] op_and    = 17'h00029;
    localparam logic [16:0] op_or     = 17'h0002a;
    localparam logic [16:0] op_xor    = 17'h0002b;
    localparam logic [16:0] op_sll_w  = 17'h0002e;
    localparam logic [16:0] op_srl_w  = 17'h0002f;
    localparam logic [16:0] op_sra_w  = 17'h00030;
    localparam logic [16:0] op_slli_w = 17'h00081;
    localparam logic [16:0] op_srli_w = 17'h00089;
    localparam logic [16:0] op_srai_w = 17'h00091;

    // inst[31:22] for the 12-bit immediate forms
    localparam logic [9:0]  op_slti   = 10'h008;
    localparam logic [9:0]  op_sltui  = 10'h009;
    localparam logic [9:0]  op_addi_w = 10'h00a;
    localparam logic [9:0]  op_andi   = 10'h00d;
    localparam logic [9:0]  op_ori    = 10'h00e;
    localparam logic [9:0]  op_xori   = 10'h00f;
    localparam logic [9:0]  op_ld_w   = 10'h0a2;
    localparam logic [9:0]  op_st_w   = 10'h0a6;

    localparam logic [6:0]  op_lu12i_w   = 7'h0a;   // inst[31:25]
    localparam logic [6:0]  op_pcaddu12i = 7'h0e;

    // inst[31:26]
    localparam logic [5:0]  op_jirl = 6'h13;
    localparam logic [5:0]  op_b    = 6'h14;
    localparam logic [5:0]  op_bl   = 6'h15;
    localparam logic [5:0]  op_beq  = 6'h16;
    localparam logic [5:0]  op_bne  = 6'h17;

endpackage
